// File: rtl/dbg_ext_regs.sv
`timescale 1ns/1ps

module dbg_ext_regs #(
  parameter int MAX_REG_SIZE = 64,
  parameter int EXT_NUM_REGS = 8
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    reg_request,
  input  logic                    reg_write,
  input  logic [15:0]             reg_addr,
  input  dbg_pkg::dbg_size_e      reg_size,
  input  logic [MAX_REG_SIZE-1:0] reg_wdata,
  output logic                    reg_ack,
  output logic                    reg_err,
  output logic [MAX_REG_SIZE-1:0] reg_rdata
);
  import dbg_pkg::*;

  localparam int IDX_W = (EXT_NUM_REGS > 1) ? $clog2(EXT_NUM_REGS) : 1;

  logic [MAX_REG_SIZE-1:0] regs [EXT_NUM_REGS];
  logic [15:0]             offset;     // Address relative to bank
  logic [IDX_W-1:0]        idx;
  logic                    hit;
  logic                    pending;    // Request already answered
  logic [MAX_REG_SIZE-1:0] wmask;      // Bits covered by the access size

  assign offset = reg_addr - EXT_BASE;
  assign idx    = offset[IDX_W-1:0];
  assign hit    = (reg_addr >= EXT_BASE) && (offset < 16'(EXT_NUM_REGS));

  // 16, 32 or 64 low bits; full width saturates to all ones
  assign wmask = ~({MAX_REG_SIZE{1'b1}} << (8'd16 << reg_size));

  //////////////////////////////////////////////////
  // Register bank and handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= 1'b0;
      reg_ack <= 1'b0;
      reg_err <= 1'b0;
      for (int i = 0; i < EXT_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      reg_ack <= 1'b0;                 // One-cycle pulses
      reg_err <= 1'b0;
      if (!reg_request) begin
        pending <= 1'b0;
      end else if (!pending) begin
        pending <= 1'b1;
        if (!hit) begin
          reg_err <= 1'b1;             // Index beyond bank
        end else begin
          reg_ack <= 1'b1;
          if (reg_write) regs[idx] <= (regs[idx] & ~wmask) | (reg_wdata & wmask);
        end
      end
    end
  end

  // Whole register back; the unit picks the low words
  always_ff @(posedge clk) begin
    if (reg_request && !pending && hit) reg_rdata <= regs[idx];
  end

endmodule

// File: rtl/dbg_module_top.sv
`timescale 1ns/1ps

module dbg_module_top #(
  parameter int MAX_REG_SIZE = 64,
  parameter int FIFO_DEPTH   = 4,
  parameter int EXT_NUM_REGS = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  dbg_pkg::dbg_word_t id,
  input  dbg_pkg::dbg_flit_t in_flit,
  input  logic               in_valid,
  output logic               in_ready,
  output dbg_pkg::dbg_flit_t out_flit,
  output logic               out_valid,
  input  logic               out_ready,
  output dbg_pkg::dbg_word_t event_dest,
  output logic               stall
);
  import dbg_pkg::*;

  //////////////////////////////////////////////////
  // Buffer to access unit
  //////////////////////////////////////////////////

  dbg_flit_t buf_flit;
  logic      buf_valid;
  logic      buf_ready;

  // Register port
  logic                    reg_request;
  logic                    reg_write;
  logic [15:0]             reg_addr;
  dbg_size_e               reg_size;
  logic [MAX_REG_SIZE-1:0] reg_wdata;
  logic                    reg_ack;
  logic                    reg_err;
  logic [MAX_REG_SIZE-1:0] reg_rdata;

  dbg_word_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .rst,
    .in_flit, .in_valid, .in_ready,
    .out_flit(buf_flit), .out_valid(buf_valid), .out_ready(buf_ready)
  );

  dbg_reg_access #(.MAX_REG_SIZE(MAX_REG_SIZE)) u_access (
    .clk, .rst, .id,
    .in_flit(buf_flit), .in_valid(buf_valid), .in_ready(buf_ready),
    .out_flit, .out_valid, .out_ready,
    .reg_request, .reg_write, .reg_addr, .reg_size, .reg_wdata,
    .reg_ack, .reg_err, .reg_rdata,
    .event_dest, .stall
  );

  dbg_ext_regs #(.MAX_REG_SIZE(MAX_REG_SIZE), .EXT_NUM_REGS(EXT_NUM_REGS)) u_ext (
    .clk, .rst,
    .reg_request, .reg_write, .reg_addr, .reg_size, .reg_wdata,
    .reg_ack, .reg_err, .reg_rdata
  );

endmodule

// File: rtl/dbg_pkg.sv
package dbg_pkg;

  //////////////////////////////////////////////////
  // Network words
  //////////////////////////////////////////////////

  typedef logic [15:0] dbg_word_t;   // One debug network word

  typedef struct packed {
    dbg_word_t data;
    logic      last;                 // Set on final word of a packet
  } dbg_flit_t;

  // Access size field of a request
  typedef enum logic [1:0] {
    SIZE_16  = 2'd0,
    SIZE_32  = 2'd1,
    SIZE_64  = 2'd2,
    SIZE_128 = 2'd3                  // Never accepted
  } dbg_size_e;

  //////////////////////////////////////////////////
  // Flags word, request and response views
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [1:0] typ;                 // 00 for register access
    logic       write;
    logic       rsvd_a;
    dbg_size_e  size;
    logic [9:0] rsvd_b;
  } dbg_req_flags_t;

  typedef struct packed {
    logic [1:0] typ;
    logic [3:0] type_sub;            // Result code
    logic [9:0] rsvd;
  } dbg_resp_flags_t;

  // Same 16 bits, decoded on input or built on output
  typedef union packed {
    dbg_req_flags_t  req;
    dbg_resp_flags_t resp;
  } dbg_flags_u;

  // Response codes
  localparam logic [3:0] RESP_READ_OK_BASE = 4'b1000;   // Low two bits carry the size
  localparam logic [3:0] RESP_READ_ERR     = 4'b1100;
  localparam logic [3:0] RESP_WRITE_OK     = 4'b1110;
  localparam logic [3:0] RESP_WRITE_ERR    = 4'b1111;

  //////////////////////////////////////////////////
  // Register map and identity
  //////////////////////////////////////////////////

  localparam dbg_word_t REG_VENDOR       = 16'h0000;
  localparam dbg_word_t REG_TYPE         = 16'h0001;
  localparam dbg_word_t REG_VERSION      = 16'h0002;
  localparam dbg_word_t REG_CS           = 16'h0003;   // Bit 0 is the active bit
  localparam dbg_word_t REG_EVENT_DEST   = 16'h0004;
  localparam dbg_word_t LOCAL_ADDR_LIMIT = 16'h0200;   // First non-local address

  localparam dbg_word_t MOD_VENDOR       = 16'h0001;
  localparam dbg_word_t MOD_TYPE         = 16'h0010;
  localparam dbg_word_t MOD_VERSION      = 16'h0000;
  localparam dbg_word_t EVENT_DEST_RESET = 16'h0000;

  localparam dbg_word_t EXT_BASE         = 16'h0200;   // External register 0

endpackage

// File: rtl/dbg_reg_access.sv
`timescale 1ns/1ps

module dbg_reg_access #(
  parameter int MAX_REG_SIZE = 64
) (
  input  logic                    clk,
  input  logic                    rst,
  input  dbg_pkg::dbg_word_t      id,
  input  dbg_pkg::dbg_flit_t      in_flit,
  input  logic                    in_valid,
  output logic                    in_ready,
  output dbg_pkg::dbg_flit_t      out_flit,
  output logic                    out_valid,
  input  logic                    out_ready,
  output logic                    reg_request,
  output logic                    reg_write,
  output logic [15:0]             reg_addr,
  output dbg_pkg::dbg_size_e      reg_size,
  output logic [MAX_REG_SIZE-1:0] reg_wdata,
  input  logic                    reg_ack,
  input  logic                    reg_err,
  input  logic [MAX_REG_SIZE-1:0] reg_rdata,
  output dbg_pkg::dbg_word_t      event_dest,
  output logic                    stall
);
  import dbg_pkg::*;

  // Largest size code this build accepts
  localparam dbg_size_e MAX_SIZE = (MAX_REG_SIZE == 16) ? SIZE_16 :
                                   (MAX_REG_SIZE == 32) ? SIZE_32 : SIZE_64;

  //////////////////////////////////////////////////
  // FSM encoding
  //////////////////////////////////////////////////

  localparam logic [3:0] ST_HDR_DEST   = 4'd0;
  localparam logic [3:0] ST_HDR_SRC    = 4'd1;
  localparam logic [3:0] ST_HDR_FLAGS  = 4'd2;
  localparam logic [3:0] ST_ADDR       = 4'd3;
  localparam logic [3:0] ST_WRITE      = 4'd4;   // Data words
  localparam logic [3:0] ST_DROP       = 4'd5;   // Skip to end of packet
  localparam logic [3:0] ST_EXT        = 4'd6;   // External access in flight
  localparam logic [3:0] ST_RESP_DEST  = 4'd7;
  localparam logic [3:0] ST_RESP_SRC   = 4'd8;
  localparam logic [3:0] ST_RESP_FLAGS = 4'd9;
  localparam logic [3:0] ST_RESP_VALUE = 4'd10;

  logic [3:0]              state;
  logic                    cs_active;        // Active bit of REG_CS
  logic                    req_write;
  dbg_size_e               req_size;
  logic [15:0]             req_addr;
  logic [2:0]              word_cnt;         // Words left minus one
  logic [MAX_REG_SIZE-1:0] value;            // Write data or read result
  dbg_word_t               resp_dest;        // Requester, from source word
  logic                    resp_error;

  dbg_flags_u              in_flags;
  dbg_flags_u              out_flags;
  logic                    in_hs;
  logic                    out_hs;
  logic [MAX_REG_SIZE-1:0] local_rdata;
  logic                    local_rd_ok;
  logic                    local_wr_ok;

  assign in_hs    = in_valid && in_ready;
  assign out_hs   = out_valid && out_ready;
  assign in_flags = in_flit.data;            // Request view on input
  assign stall    = ~cs_active;

  assign reg_write = req_write;
  assign reg_addr  = req_addr;
  assign reg_size  = req_size;
  assign reg_wdata = value;

  // Local read decode, on the address word
  always_comb begin
    local_rd_ok = 1'b1;
    case (in_flit.data)
      REG_VENDOR:     local_rdata = MAX_REG_SIZE'(MOD_VENDOR);
      REG_TYPE:       local_rdata = MAX_REG_SIZE'(MOD_TYPE);
      REG_VERSION:    local_rdata = MAX_REG_SIZE'(MOD_VERSION);
      REG_CS:         local_rdata = MAX_REG_SIZE'(cs_active);
      REG_EVENT_DEST: local_rdata = MAX_REG_SIZE'(event_dest);
      default: begin
        local_rdata = '0;
        local_rd_ok = 1'b0;                  // Unknown local address
      end
    endcase
  end

  // Only 16-bit writes to CS or event destination
  assign local_wr_ok = (req_size == SIZE_16) &&
                       (in_flit.data == REG_CS || in_flit.data == REG_EVENT_DEST);

  //////////////////////////////////////////////////
  // Handshake and response word
  //////////////////////////////////////////////////

  always_comb begin
    in_ready    = (state <= ST_DROP);        // All request states
    out_valid   = (state >= ST_RESP_DEST);
    reg_request = (state == ST_EXT);

    out_flags.resp.typ  = 2'b00;
    out_flags.resp.rsvd = '0;
    if (req_write) begin
      out_flags.resp.type_sub = resp_error ? RESP_WRITE_ERR : RESP_WRITE_OK;
    end else begin
      out_flags.resp.type_sub = resp_error ? RESP_READ_ERR :
                                (RESP_READ_OK_BASE | {2'b00, req_size});
    end

    case (state)
      ST_RESP_DEST:  out_flit = '{data: resp_dest, last: 1'b0};
      ST_RESP_SRC:   out_flit = '{data: id, last: 1'b0};
      ST_RESP_FLAGS: out_flit = '{data: dbg_word_t'(out_flags),
                                  last: resp_error | req_write};
      ST_RESP_VALUE: out_flit = '{data: dbg_word_t'(value >> {word_cnt, 4'b0000}),
                                  last: (word_cnt == 3'd0)};   // MSW first
      default:       out_flit = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Request parser and register updates
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_HDR_DEST;
      cs_active  <= 1'b0;
      event_dest <= EVENT_DEST_RESET;
    end else begin
      case (state)
        ST_HDR_DEST: if (in_hs && !in_flit.last) state <= ST_HDR_SRC;
        ST_HDR_SRC: if (in_hs) begin
          resp_dest  <= in_flit.data;          // Reply goes back here
          req_write  <= 1'b0;
          resp_error <= in_flit.last;          // Ends early
          state      <= in_flit.last ? ST_RESP_DEST : ST_HDR_FLAGS;
        end
        ST_HDR_FLAGS: if (in_hs) begin
          req_write <= in_flags.req.write;
          req_size  <= in_flags.req.size;
          word_cnt  <= (3'd1 << in_flags.req.size) - 3'd1;
          if (in_flags.req.typ != 2'b00 || in_flags.req.size > MAX_SIZE || in_flit.last) begin
            resp_error <= 1'b1;
            state      <= in_flit.last ? ST_RESP_DEST : ST_DROP;
          end else begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: if (in_hs) begin
          req_addr <= in_flit.data;
          value    <= '0;
          if (in_flit.data >= LOCAL_ADDR_LIMIT) begin
            if (req_write == in_flit.last) begin   // Write w/o data, or read with extra
              resp_error <= 1'b1;
              state      <= in_flit.last ? ST_RESP_DEST : ST_DROP;
            end else begin
              state <= req_write ? ST_WRITE : ST_EXT;
            end
          end else if (req_write) begin
            if (in_flit.last || !local_wr_ok) begin
              resp_error <= 1'b1;
              state      <= in_flit.last ? ST_RESP_DEST : ST_DROP;
            end else begin
              state <= ST_WRITE;
            end
          end else begin
            value      <= local_rdata;
            resp_error <= !local_rd_ok || !in_flit.last;
            state      <= in_flit.last ? ST_RESP_DEST : ST_DROP;
          end
        end
        ST_WRITE: if (in_hs) begin
          if (req_addr >= LOCAL_ADDR_LIMIT) begin
            value <= (value << 16) | MAX_REG_SIZE'(in_flit.data);   // Shift in MSW first
            if (word_cnt == 3'd0) begin
              resp_error <= !in_flit.last;   // Extra words
              state      <= in_flit.last ? ST_EXT : ST_DROP;
            end else if (in_flit.last) begin
              resp_error <= 1'b1;            // Too few words
              state      <= ST_RESP_DEST;
            end else begin
              word_cnt <= word_cnt - 3'd1;
            end
          end else if (in_flit.last) begin
            if (req_addr == REG_CS) cs_active <= in_flit.data[0];
            else event_dest <= in_flit.data;
            state <= ST_RESP_DEST;
          end else begin
            resp_error <= 1'b1;              // Local write takes one word
            state      <= ST_DROP;
          end
        end
        ST_DROP: if (in_hs && in_flit.last) state <= ST_RESP_DEST;
        ST_EXT: if (reg_ack || reg_err) begin
          value      <= reg_rdata;
          resp_error <= reg_err;
          state      <= ST_RESP_DEST;
        end
        ST_RESP_DEST: if (out_hs) state <= ST_RESP_SRC;
        ST_RESP_SRC:  if (out_hs) state <= ST_RESP_FLAGS;
        ST_RESP_FLAGS: if (out_hs) begin
          state <= (resp_error || req_write) ? ST_HDR_DEST : ST_RESP_VALUE;
        end
        ST_RESP_VALUE: if (out_hs) begin
          if (word_cnt == 3'd0) state <= ST_HDR_DEST;
          else word_cnt <= word_cnt - 3'd1;
        end
        default: state <= ST_HDR_DEST;
      endcase
    end
  end

  // Bank sees a steady request until it answers
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    reg_request && !(reg_ack || reg_err) |=> reg_request && $stable(reg_addr));

  a_req_drop: assert property (@(posedge clk) disable iff (rst)
    reg_request && (reg_ack || reg_err) |=> !reg_request);

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

// File: rtl/dbg_word_fifo.sv
`timescale 1ns/1ps

module dbg_word_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  dbg_pkg::dbg_flit_t in_flit,
  input  logic               in_valid,
  output logic               in_ready,
  output dbg_pkg::dbg_flit_t out_flit,
  output logic               out_valid,
  input  logic               out_ready
);
  import dbg_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [PTR_W:0] FULL_CNT = (PTR_W + 1)'(FIFO_DEPTH);

  dbg_flit_t        mem [FIFO_DEPTH];   // Flit storage
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;              // Words held
  logic [PTR_W:0]   count_nxt;
  logic             push;
  logic             pop;

  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign out_valid = (count != '0);
  assign out_flit  = mem[rd_ptr];       // Head of queue

  always_comb begin
    count_nxt = count;
    if (push && !pop) count_nxt = count + 1'b1;
    else if (pop && !push) count_nxt = count - 1'b1;   // Both at once, count holds
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= in_flit;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      in_ready <= 1'b0;                 // Opens one cycle after reset
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at power of two
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count    <= count_nxt;
      in_ready <= (count_nxt != FULL_CNT);
    end
  end

  // Registered ready must track the fill level
  a_no_push_full: assert property (@(posedge clk) disable iff (rst)
    !(push && count == FULL_CNT));

  a_out_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_flit));

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile the debug endpoint testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_dbg_top -Mdir "$OBJ" -o sim_bin
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/sim_bin" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: sim.f
rtl/dbg_pkg.sv
rtl/dbg_word_fifo.sv
rtl/dbg_reg_access.sv
rtl/dbg_ext_regs.sv
rtl/dbg_module_top.sv
tests/tb_dbg_top.sv

// File: tests/tb_dbg_top.sv
`timescale 1ns/1ps

module tb_dbg_top;
  import dbg_pkg::*;

  localparam int        EXT_REGS   = 8;
  localparam int        MAX_CYCLES = 4000;   // Roughly ten times all packet words
  localparam dbg_word_t NODE_ID    = 16'h0a5c;

  logic      clk = 1'b0;
  logic      rst;
  dbg_word_t id;
  dbg_flit_t in_flit;
  logic      in_valid;
  logic      in_ready;
  dbg_flit_t out_flit;
  logic      out_valid;
  logic      out_ready;
  dbg_word_t event_dest;
  logic      stall;

  integer      seed = 32'h7d093828;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          npkt = 0;                     // Requests queued but not yet run
  dbg_flit_t   tx_q[$];                      // Request words to drive
  dbg_flit_t   exp_q[$];                     // Expected response words
  logic [63:0] ext_model [EXT_REGS];         // Reference copy of the bank
  logic        cs_model;
  dbg_word_t   ev_model;

  dbg_module_top #(.MAX_REG_SIZE(64), .FIFO_DEPTH(4), .EXT_NUM_REGS(EXT_REGS)) DUT (.*);

  always #2 clk = ~clk;                      // 4 ns period

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Cycle limit of %0d reached before all responses arrived", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Checking and queue helpers
  //////////////////////////////////////////////////

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got=%h expected=%h", $time, name, got, exp);
    end
  endtask

  task automatic push_tx(input dbg_word_t d, input logic l);
    dbg_flit_t f;
    f.data = d;
    f.last = l;
    tx_q.push_back(f);
  endtask

  task automatic push_exp(input dbg_word_t d, input logic l);
    dbg_flit_t f;
    f.data = d;
    f.last = l;
    exp_q.push_back(f);
  endtask

  // Response flags: type 00, result code, reserved zero
  function automatic dbg_word_t resp_flags(input logic [3:0] code);
    return {2'b00, code, 10'b0};
  endfunction

  //////////////////////////////////////////////////
  // Request builders with expected responses
  //////////////////////////////////////////////////

  task automatic add_read(input dbg_word_t src, input dbg_word_t addr, input logic [1:0] size);
    logic [63:0] val;
    logic        ok;
    int          nw;
    nw  = 1 << size;
    ok  = 1'b1;
    val = '0;
    push_tx(NODE_ID, 1'b0);
    push_tx(src, 1'b0);
    push_tx({4'b0000, size, 10'b0}, 1'b0);   // Read, register access type
    push_tx(addr, 1'b1);
    if (size == 2'd3) ok = 1'b0;             // 128 bit never served
    else if (addr < LOCAL_ADDR_LIMIT) begin
      case (addr)
        REG_VENDOR:     val = 64'(MOD_VENDOR);
        REG_TYPE:       val = 64'(MOD_TYPE);
        REG_VERSION:    val = 64'(MOD_VERSION);
        REG_CS:         val = 64'(cs_model);
        REG_EVENT_DEST: val = 64'(ev_model);
        default:        ok = 1'b0;
      endcase
    end else if (32'(addr - EXT_BASE) >= EXT_REGS) ok = 1'b0;
    else val = ext_model[addr - EXT_BASE];
    push_exp(src, 1'b0);                     // Back to requester
    push_exp(NODE_ID, 1'b0);
    if (!ok) push_exp(resp_flags(RESP_READ_ERR), 1'b1);
    else begin
      push_exp(resp_flags({2'b10, size}), 1'b0);
      for (int i = nw - 1; i >= 0; i--) push_exp(val[16*i +: 16], i == 0);   // MSW first
    end
    npkt++;
  endtask

  // trunc ends the packet at the address word
  task automatic add_write(input dbg_word_t src, input dbg_word_t addr, input logic [1:0] size,
                           input logic [63:0] data, input logic trunc);
    logic [63:0] mask;
    logic        ok;
    int          nw;
    nw = 1 << size;
    push_tx(NODE_ID, 1'b0);
    push_tx(src, 1'b0);
    push_tx({4'b0010, size, 10'b0}, 1'b0);   // Write bit set
    push_tx(addr, trunc);
    if (!trunc) for (int i = nw - 1; i >= 0; i--) push_tx(data[16*i +: 16], i == 0);
    ok = !trunc;
    if (ok && addr < LOCAL_ADDR_LIMIT) begin
      if (size == SIZE_16 && addr == REG_CS) cs_model = data[0];
      else if (size == SIZE_16 && addr == REG_EVENT_DEST) ev_model = data[15:0];
      else ok = 1'b0;                        // Only one-word writes to CS or event dest
    end else if (ok && 32'(addr - EXT_BASE) >= EXT_REGS) ok = 1'b0;
    else if (ok) begin
      mask = (nw == 4) ? '1 : ((64'd1 << (16 * nw)) - 64'd1);
      ext_model[addr - EXT_BASE] = (ext_model[addr - EXT_BASE] & ~mask) | (data & mask);
    end
    push_exp(src, 1'b0);
    push_exp(NODE_ID, 1'b0);
    push_exp(resp_flags(ok ? RESP_WRITE_OK : RESP_WRITE_ERR), 1'b1);
    npkt++;
  endtask

  //////////////////////////////////////////////////
  // Packet transfer, all driven on the falling edge
  //////////////////////////////////////////////////

  task automatic send_packet();
    dbg_flit_t f;
    f.last = 1'b0;
    while (!f.last && tx_q.size() != 0) begin
      f        = tx_q.pop_front();
      in_flit  = f;
      in_valid = 1'b1;
      while (!in_ready) @(negedge clk);      // Registered ready, stable here
      @(negedge clk);                        // Taken at the posedge between
    end
  endtask

  task automatic recv_packet(input logic rand_bp);
    dbg_flit_t got;
    dbg_flit_t exp;
    logic      done;
    integer    r;
    done = 1'b0;
    while (!done) begin
      r         = $random(seed);
      out_ready = rand_bp ? (r[0] | r[1]) : 1'b1;   // About 3 in 4 when random
      if (out_valid && out_ready) begin
        got = out_flit;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Response word %h arrived with no response expected", got.data);
        end else begin
          exp = exp_q.pop_front();
          check("out_flit.data", got.data, exp.data);
          check("out_flit.last", got.last, exp.last);
        end
        done = got.last;
      end
      @(negedge clk);
    end
  endtask

  // Sender and receiver run together so the FIFO can fill
  task automatic run_traffic(input logic rand_bp);
    int n;
    n    = npkt;
    npkt = 0;
    @(negedge clk);
    fork
      begin
        repeat (n) send_packet();
        in_valid = 1'b0;
      end
      begin
        repeat (n) recv_packet(rand_bp);
        out_ready = 1'b0;
      end
    join
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected response words never arrived", exp_q.size());
      exp_q.delete();
    end
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_local_reads();
    add_read(16'h0101, REG_VENDOR, SIZE_16);
    add_read(16'h0102, REG_TYPE, SIZE_16);
    add_read(16'h0103, REG_VERSION, SIZE_16);
    add_read(16'h0104, REG_CS, SIZE_16);
    add_read(16'h0105, REG_EVENT_DEST, SIZE_16);
    run_traffic(1'b0);
  endtask

  task automatic test_local_writes();
    add_write(16'h0111, REG_CS, SIZE_16, 64'h1, 1'b0);          // Set active
    add_write(16'h0112, REG_EVENT_DEST, SIZE_16, 64'h1234, 1'b0);
    run_traffic(1'b0);
    check("stall", stall, 64'd0);
    check("event_dest", event_dest, 64'h1234);
    add_read(16'h0113, REG_CS, SIZE_16);
    add_read(16'h0114, REG_EVENT_DEST, SIZE_16);
    run_traffic(1'b0);
  endtask

  task automatic test_ext_access();
    add_write(16'h0121, EXT_BASE, SIZE_64, 64'h1122334455667788, 1'b0);
    add_write(16'h0122, EXT_BASE + 16'd1, SIZE_32, 64'hcafef00d, 1'b0);
    add_write(16'h0123, EXT_BASE + 16'd7, SIZE_16, 64'hbeef, 1'b0);   // Last register
    add_read(16'h0124, EXT_BASE, SIZE_64);
    add_read(16'h0125, EXT_BASE + 16'd1, SIZE_32);
    add_read(16'h0126, EXT_BASE + 16'd7, SIZE_16);
    add_write(16'h0127, EXT_BASE, SIZE_16, 64'haaaa, 1'b0);         // Upper 48 bits stay
    add_read(16'h0128, EXT_BASE, SIZE_64);
    add_read(16'h0129, EXT_BASE, SIZE_32);
    run_traffic(1'b0);
  endtask

  // Each bad request is followed by a good one
  task automatic test_errors();
    add_read(16'h0131, REG_VENDOR, SIZE_128);
    add_read(16'h0132, REG_VENDOR, SIZE_16);
    add_read(16'h0133, 16'h0010, SIZE_16);                          // Unknown local
    add_read(16'h0134, REG_TYPE, SIZE_16);
    add_write(16'h0135, REG_CS, SIZE_32, 64'h0, 1'b0);              // CS must stay set
    add_read(16'h0136, REG_CS, SIZE_16);
    add_read(16'h0137, EXT_BASE + 16'(EXT_REGS), SIZE_16);         // Past the bank
    add_read(16'h0138, EXT_BASE, SIZE_64);
    add_write(16'h0139, EXT_BASE + 16'd1, SIZE_32, 64'h0, 1'b1);    // No data words
    add_read(16'h013a, EXT_BASE + 16'd1, SIZE_32);
    run_traffic(1'b0);
  endtask

  task automatic test_backpressure();
    logic [63:0] d;
    for (int i = 0; i < 4; i++) begin
      d = {$random(seed), $random(seed)};
      add_write(16'h0140 + 16'(i), EXT_BASE + 16'(i + 2), 2'(i % 3), d, 1'b0);
      add_read(16'h0150 + 16'(i), EXT_BASE + 16'(i + 2), SIZE_64);
      add_read(16'h0160 + 16'(i), 16'(i), SIZE_16);               // Vendor up to CS
    end
    add_read(16'h0170, REG_EVENT_DEST, SIZE_16);
    run_traffic(1'b1);
  endtask

  initial begin
    rst       = 1'b1;
    id        = NODE_ID;
    in_flit   = '0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    cs_model  = 1'b0;
    ev_model  = EVENT_DEST_RESET;
    for (int i = 0; i < EXT_REGS; i++) ext_model[i] = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    check("in_ready", in_ready, 64'd0);      // Closed while in reset
    check("out_valid", out_valid, 64'd0);
    check("out_flit.last", out_flit.last, 64'd0);
    rst = 1'b0;
    check("stall", stall, 64'd1);            // Inactive out of reset
    check("event_dest", event_dest, 64'(EVENT_DEST_RESET));
    test_local_reads();
    test_local_writes();
    test_ext_access();
    test_errors();
    test_backpressure();
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) $display("TEST PASS");
    else $display("TEST FAIL");
    $finish;
  end

endmodule
